// ==== rr_defs.svh ====
`ifndef RR_DEFS_SVH
`define RR_DEFS_SVH

// datapath and address width
`define RR_XLEN 32

// architectural registers and the width of an index into them
`define RR_NREG 32
`define RR_REG_AW 5

// execute advances before a load result reaches the forwarding network
`define RR_LOAD_SHADOW 2

// andi r0, r0, 0
`define RR_INST_NOP 32'h0340_0000

`endif

// ==== issue_pkg.sv ====
`default_nettype none
`include "rr_defs.svh"

package issue_pkg;

    // micro-op control word, 16 bits
    typedef struct packed {
        logic       mem;
        // bit 2 set for store-like accesses
        logic [3:0] cond;
        logic [5:0] alu_op;
        logic [4:0] sub_op;
    } uop_t;

    // one decoded instruction slot
    typedef struct packed {
        logic [`RR_XLEN-1:0]   pc;
        logic [`RR_XLEN-1:0]   inst;
        uop_t                  uop;
        logic [`RR_XLEN-1:0]   imm;
        logic [`RR_REG_AW-1:0] rj;
        logic [`RR_REG_AW-1:0] rk;
        logic [`RR_REG_AW-1:0] rd;
        logic                  is_alu;
        logic                  is_syscall;
        logic                  is_break;
        logic                  is_priv;
    } slot_t;

    // decode handover, two slots plus branch and exception state
    typedef struct packed {
        slot_t               slot0;
        slot_t               slot1;
        logic [`RR_XLEN-1:0] pc_next;
        logic                pc_taken;
        logic                cmt;
        logic                branch_flag;
        logic                excp_flag;
        logic [6:0]          exception;
        logic [`RR_XLEN-1:0] badv;
    } bundle_t;

    // bundle with its source operands, as seen by execute
    typedef struct packed {
        bundle_t             bundle;
        logic [`RR_XLEN-1:0] rj0_data;
        logic [`RR_XLEN-1:0] rk0_data;
        logic [`RR_XLEN-1:0] rj1_data;
        logic [`RR_XLEN-1:0] rk1_data;
    } ex_bundle_t;

endpackage

`default_nettype wire

// ==== bypass_pkg.sv ====
`default_nettype none
`include "rr_defs.svh"

package bypass_pkg;

    // one register file write port
    typedef struct packed {
        logic                  we;
        logic [`RR_REG_AW-1:0] addr;
        logic [`RR_XLEN-1:0]   data;
    } wb_port_t;

    // forwarded value for one held operand
    typedef struct packed {
        logic                flag;
        logic [`RR_XLEN-1:0] data;
    } fwd_t;

    // updates for rj0, rk0, rj1, rk1 in that order
    typedef struct packed {
        fwd_t j0;
        fwd_t k0;
        fwd_t j1;
        fwd_t k1;
    } fwd_set_t;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rr_defs.svh"

module regfile (
    input  wire                             clk,
    input  wire                             aresetn,
    input  wire bypass_pkg::wb_port_t       wb0,
    input  wire bypass_pkg::wb_port_t       wb1,
    // rj0, rk0, rj1, rk1
    input  wire  [3:0][`RR_REG_AW-1:0]      raddr,
    output logic [3:0][`RR_XLEN-1:0]        rdata
);

    logic [`RR_NREG-1:0][`RR_XLEN-1:0] regs;

    // r0 never written
    // port 1 comes last so it wins when both hit one address
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            regs <= '0;
        end else begin
            if (wb0.we && wb0.addr != '0) begin
                regs[wb0.addr] <= wb0.data;
            end
            if (wb1.we && wb1.addr != '0) begin
                regs[wb1.addr] <= wb1.data;
            end
        end
    end

    // write-first reads, newest writeback ahead of array content
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else if (wb1.we && wb1.addr == raddr[i]) begin
                rdata[i] = wb1.data;
            end else if (wb0.we && wb0.addr == raddr[i]) begin
                rdata[i] = wb0.data;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== load_use_guard.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rr_defs.svh"

module load_use_guard (
    input  wire                         clk,
    input  wire                         aresetn,
    input  wire                         ex_advance,
    input  wire issue_pkg::uop_t        ex_uop,
    input  wire  [`RR_REG_AW-1:0]       ex_rd,
    input  wire  [3:0][`RR_REG_AW-1:0]  src,
    output logic                        stall
);

    logic                                        is_load;
    logic [`RR_REG_AW-1:0]                       ex_load_rd;
    logic [`RR_LOAD_SHADOW-1:0][`RR_REG_AW-1:0]  history;
    logic [`RR_LOAD_SHADOW:0][`RR_REG_AW-1:0]    tracked;

    // memory access that is not store-like
    assign is_load    = ex_uop.mem && !ex_uop.cond[2];
    assign ex_load_rd = is_load ? ex_rd : '0;

    // non-loads shift in r0, which never matches
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            history <= '0;
        end else if (ex_advance) begin
            history[0] <= ex_load_rd;
            for (int i = 1; i < `RR_LOAD_SHADOW; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

    // current execute load plus every load still in its shadow
    assign tracked = {history, ex_load_rd};

    always_comb begin
        stall = 1'b0;
        for (int t = 0; t <= `RR_LOAD_SHADOW; t++) begin
            for (int s = 0; s < 4; s++) begin
                if (tracked[t] != '0 && tracked[t] == src[s]) begin
                    stall = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== ex_issue_reg.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rr_defs.svh"

module ex_issue_reg (
    input  wire                          clk,
    input  wire                          aresetn,
    input  wire                          flush,
    input  wire                          flush_by_priv,
    input  wire                          transfer,
    input  wire                          ex_advance,
    input  wire                          ex_allowin,
    input  wire issue_pkg::bundle_t      id_bundle,
    // rj0, rk0, rj1, rk1 from the register file
    input  wire  [3:0][`RR_XLEN-1:0]     operand,
    input  wire bypass_pkg::fwd_set_t    fwd,
    output issue_pkg::ex_bundle_t        ex_bundle
);

    // empty bundle, both instruction words are NOP
    function automatic issue_pkg::ex_bundle_t make_bubble();
        issue_pkg::ex_bundle_t b;
        b = '0;
        b.bundle.slot0.inst = `RR_INST_NOP;
        b.bundle.slot1.inst = `RR_INST_NOP;
        return b;
    endfunction

    localparam issue_pkg::ex_bundle_t bubble = make_bubble();

    logic clear;
    logic drain;

    // privileged flush is unconditional, a normal one waits for execute
    assign clear = flush_by_priv || (flush && ex_allowin);

    // execute moves on and nothing arrives behind it
    assign drain = ex_advance && !transfer;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_bundle <= bubble;
        end else if (clear) begin
            ex_bundle <= bubble;
        end else if (drain) begin
            ex_bundle <= bubble;
        end else if (transfer) begin
            ex_bundle.bundle   <= id_bundle;
            ex_bundle.rj0_data <= operand[0];
            ex_bundle.rk0_data <= operand[1];
            ex_bundle.rj1_data <= operand[2];
            ex_bundle.rk1_data <= operand[3];
        end else begin
            // held in place, pick up late results from execute
            if (fwd.j0.flag) begin
                ex_bundle.rj0_data <= fwd.j0.data;
            end
            if (fwd.k0.flag) begin
                ex_bundle.rk0_data <= fwd.k0.data;
            end
            if (fwd.j1.flag) begin
                ex_bundle.rj1_data <= fwd.j1.data;
            end
            if (fwd.k1.flag) begin
                ex_bundle.rk1_data <= fwd.k1.data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reg_read_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rr_defs.svh"

module reg_read_stage (
    input  wire                          clk,
    input  wire                          aresetn,
    input  wire                          flush,
    input  wire                          flush_by_priv,
    input  wire                          reg_readygo,
    input  wire                          ex_allowin,
    input  wire                          forward_stall,
    input  wire issue_pkg::bundle_t      id_bundle,
    input  wire bypass_pkg::wb_port_t    wb0,
    input  wire bypass_pkg::wb_port_t    wb1,
    input  wire bypass_pkg::fwd_set_t    fwd,
    output logic                         reg_allowin,
    output logic                         ex_readygo,
    output issue_pkg::ex_bundle_t        ex_bundle
);

    logic [3:0][`RR_REG_AW-1:0] src;
    logic [3:0][`RR_XLEN-1:0]   operand;
    logic                       load_stall;
    logic                       transfer;
    logic                       ex_advance;

    // operand order matches the forwarding set
    assign src[0] = id_bundle.slot0.rj;
    assign src[1] = id_bundle.slot0.rk;
    assign src[2] = id_bundle.slot1.rj;
    assign src[3] = id_bundle.slot1.rk;

    // flow control
    assign ex_readygo  = !forward_stall;
    assign reg_allowin = ex_allowin && !forward_stall && !load_stall;
    assign transfer    = reg_readygo && reg_allowin && ex_allowin;
    assign ex_advance  = ex_allowin && ex_readygo;

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .wb0     (wb0),
        .wb1     (wb1),
        .raddr   (src),
        .rdata   (operand)
    );

    // only slot0 can carry a load in this core
    load_use_guard u_load_use_guard (
        .clk        (clk),
        .aresetn    (aresetn),
        .ex_advance (ex_advance),
        .ex_uop     (ex_bundle.bundle.slot0.uop),
        .ex_rd      (ex_bundle.bundle.slot0.rd),
        .src        (src),
        .stall      (load_stall)
    );

    ex_issue_reg u_ex_issue_reg (
        .clk           (clk),
        .aresetn       (aresetn),
        .flush         (flush),
        .flush_by_priv (flush_by_priv),
        .transfer      (transfer),
        .ex_advance    (ex_advance),
        .ex_allowin    (ex_allowin),
        .id_bundle     (id_bundle),
        .operand       (operand),
        .fwd           (fwd),
        .ex_bundle     (ex_bundle)
    );

endmodule

`default_nettype wire

// ==== tb_reg_read_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rr_defs.svh"

module tb_reg_read_stage;

    // summed length of the directed tests, with margin on top
    localparam int TEST_CYCLES = 400;
    localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 2;

    logic                  clk;
    logic                  aresetn;
    logic                  flush;
    logic                  flush_by_priv;
    logic                  reg_readygo;
    logic                  ex_allowin;
    logic                  forward_stall;
    issue_pkg::bundle_t    id_bundle;
    bypass_pkg::wb_port_t  wb0;
    bypass_pkg::wb_port_t  wb1;
    bypass_pkg::fwd_set_t  fwd;
    logic                  reg_allowin;
    logic                  ex_readygo;
    issue_pkg::ex_bundle_t ex_bundle;

    // architectural register contents as written by the testbench
    logic [`RR_XLEN-1:0] model [`RR_NREG];
    logic [31:0]         lfsr;
    int                  n_errors;
    int                  n_checks;
    int                  cycle_count = 0;

    reg_read_stage dut (
        .clk           (clk),
        .aresetn       (aresetn),
        .flush         (flush),
        .flush_by_priv (flush_by_priv),
        .reg_readygo   (reg_readygo),
        .ex_allowin    (ex_allowin),
        .forward_stall (forward_stall),
        .id_bundle     (id_bundle),
        .wb0           (wb0),
        .wb1           (wb1),
        .fwd           (fwd),
        .reg_allowin   (reg_allowin),
        .ex_readygo    (ex_readygo),
        .ex_bundle     (ex_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic issue_pkg::ex_bundle_t bubble_value();
        issue_pkg::ex_bundle_t e;
        e = '0;
        e.bundle.slot0.inst = `RR_INST_NOP;
        e.bundle.slot1.inst = `RR_INST_NOP;
        return e;
    endfunction

    function automatic logic [`RR_XLEN-1:0] read_model(input logic [4:0] a);
        return (a == 5'd0) ? '0 : model[a];
    endfunction

    // what execute should hold right after this bundle transfers
    function automatic issue_pkg::ex_bundle_t loaded_value(input issue_pkg::bundle_t b);
        issue_pkg::ex_bundle_t e;
        e.bundle   = b;
        e.rj0_data = read_model(b.slot0.rj);
        e.rk0_data = read_model(b.slot0.rk);
        e.rj1_data = read_model(b.slot1.rj);
        e.rk1_data = read_model(b.slot1.rk);
        return e;
    endfunction

    task automatic build_bundle(input logic [4:0] rj0, rk0, rj1, rk1,
                                output issue_pkg::bundle_t b);
        logic [31:0] w;
        b = '0;
        random_bits(32, w);
        b.slot0.pc = w;
        b.slot1.pc = w + 32'd4;
        random_bits(32, w);
        b.slot0.inst = w;
        random_bits(32, w);
        b.slot1.inst = w;
        random_bits(32, w);
        b.slot0.imm = w;
        random_bits(16, w);
        b.slot0.uop = w[15:0];
        // slot0 stays a non-load unless a test says otherwise
        b.slot0.uop.mem = 1'b0;
        random_bits(16, w);
        b.slot1.uop = w[15:0];
        random_bits(5, w);
        b.slot0.rd = w[4:0];
        b.slot0.rj = rj0;
        b.slot0.rk = rk0;
        b.slot1.rj = rj1;
        b.slot1.rk = rk1;
        b.slot0.is_alu = 1'b1;
        random_bits(32, w);
        b.pc_next = w;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_ex(input string name, input issue_pkg::ex_bundle_t exp);
        n_checks++;
        if (ex_bundle !== exp) begin
            n_errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, ex_bundle);
        end
    endtask

    // port 1 is applied last, as in the hardware
    task automatic drive_writes(input logic [4:0] a0, input logic [31:0] d0,
                                input logic [4:0] a1, input logic [31:0] d1);
        wb0.we   = 1'b1;
        wb0.addr = a0;
        wb0.data = d0;
        wb1.we   = 1'b1;
        wb1.addr = a1;
        wb1.data = d1;
        if (a0 != 5'd0) begin
            model[a0] = d0;
        end
        if (a1 != 5'd0) begin
            model[a1] = d1;
        end
    endtask

    task automatic clear_writes();
        wb0.we = 1'b0;
        wb1.we = 1'b0;
    endtask

    // present a bundle and wait for the stage to take it
    task automatic send_bundle(input issue_pkg::bundle_t b);
        int waited;
        id_bundle   = b;
        reg_readygo = 1'b1;
        waited      = 0;
        #1;
        while (!reg_allowin && waited < 20) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!reg_allowin) begin
            n_errors++;
            $display("bundle at pc %h was never accepted by the stage", b.slot0.pc);
        end
        @(negedge clk);
        reg_readygo = 1'b0;
    endtask

    task automatic test_reset();
        check_ex("ex_bundle after reset", bubble_value());
        check_bit("ex_readygo", 1'b1, ex_readygo);
        check_bit("reg_allowin", 1'b1, reg_allowin);
        ex_allowin = 1'b0;
        #1;
        check_bit("reg_allowin", 1'b0, reg_allowin);
        @(negedge clk);
        ex_allowin = 1'b1;
    endtask

    task automatic test_reg_reads();
        issue_pkg::bundle_t b;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        for (int i = 1; i < `RR_NREG; i += 2) begin
            random_bits(32, d0);
            random_bits(32, d1);
            drive_writes(5'(i), d0, 5'(i + 1), d1);
            @(negedge clk);
            clear_writes();
        end
        build_bundle(5'd1, 5'd2, 5'd3, 5'd31, b);
        send_bundle(b);
        check_ex("ex_bundle operand read", loaded_value(b));
        build_bundle(5'd0, 5'd0, 5'd17, 5'd0, b);
        send_bundle(b);
        check_ex("ex_bundle r0 read", loaded_value(b));
        repeat (4) begin
            random_bits(5, r0);
            random_bits(5, r1);
            random_bits(5, r2);
            random_bits(5, r3);
            build_bundle(r0[4:0], r1[4:0], r2[4:0], r3[4:0], b);
            send_bundle(b);
            check_ex("ex_bundle random read", loaded_value(b));
        end
        // write and read of r9 in one cycle, r0 written alongside
        random_bits(32, d0);
        random_bits(32, d1);
        drive_writes(5'd9, d0, 5'd0, d1);
        build_bundle(5'd9, 5'd9, 5'd0, 5'd3, b);
        send_bundle(b);
        clear_writes();
        check_ex("ex_bundle write-first read", loaded_value(b));
        // both ports hit r12
        random_bits(32, d0);
        random_bits(32, d1);
        drive_writes(5'd12, d0, 5'd12, d1);
        build_bundle(5'd12, 5'd0, 5'd0, 5'd12, b);
        send_bundle(b);
        clear_writes();
        check_ex("ex_bundle dual write bypass", loaded_value(b));
        build_bundle(5'd0, 5'd12, 5'd12, 5'd0, b);
        send_bundle(b);
        check_ex("ex_bundle dual write array", loaded_value(b));
    endtask

    task automatic test_load_use(input logic [3:0] cond, input logic [4:0] rd,
                                 input int pos, input int expect_cycles);
        issue_pkg::bundle_t ld;
        issue_pkg::bundle_t dep;
        int low;
        build_bundle(5'd0, 5'd0, 5'd0, 5'd0, ld);
        ld.slot0.uop.mem  = 1'b1;
        ld.slot0.uop.cond = cond;
        ld.slot0.rd       = rd;
        build_bundle(pos == 0 ? rd : 5'd0, pos == 1 ? rd : 5'd0,
                     pos == 2 ? rd : 5'd0, pos == 3 ? rd : 5'd0, dep);
        send_bundle(ld);
        id_bundle   = dep;
        reg_readygo = 1'b1;
        low = 0;
        #1;
        while (!reg_allowin && low < 10) begin
            @(negedge clk);
            #1;
            low++;
        end
        n_checks++;
        if (low != expect_cycles) begin
            n_errors++;
            $display("ERR t=%0t reg_allowin low cycles expected %0d got %0d",
                     $time, expect_cycles, low);
        end
        @(negedge clk);
        reg_readygo = 1'b0;
        check_ex("ex_bundle after load-use", loaded_value(dep));
        // let the load shadow drain
        repeat (`RR_LOAD_SHADOW + 1) @(negedge clk);
    endtask

    task automatic test_forward_patch();
        issue_pkg::bundle_t b;
        issue_pkg::ex_bundle_t exp;
        logic [31:0] d;
        build_bundle(5'd1, 5'd2, 5'd3, 5'd4, b);
        send_bundle(b);
        ex_allowin = 1'b0;
        exp = loaded_value(b);
        #1;
        check_bit("reg_allowin", 1'b0, reg_allowin);
        @(negedge clk);
        check_ex("ex_bundle held", exp);
        for (int k = 0; k < 4; k++) begin
            random_bits(32, d);
            fwd.j0.data = d;
            fwd.k0.data = ~d;
            fwd.j1.data = d ^ 32'h5a5a_5a5a;
            fwd.k1.data = d + 32'd1;
            fwd.j0.flag = (k == 0);
            fwd.k0.flag = (k == 1);
            fwd.j1.flag = (k == 2);
            fwd.k1.flag = (k == 3);
            case (k)
                0: exp.rj0_data = d;
                1: exp.rk0_data = ~d;
                2: exp.rj1_data = d ^ 32'h5a5a_5a5a;
                default: exp.rk1_data = d + 32'd1;
            endcase
            @(negedge clk);
            fwd = '0;
            check_ex("ex_bundle forward patch", exp);
        end
        ex_allowin = 1'b1;
        @(negedge clk);
        check_ex("ex_bundle drained", bubble_value());
    endtask

    task automatic test_flushes();
        issue_pkg::bundle_t b;
        issue_pkg::bundle_t b2;
        build_bundle(5'd5, 5'd6, 5'd7, 5'd8, b);
        build_bundle(5'd9, 5'd10, 5'd11, 5'd12, b2);
        // flush wins over a pending transfer
        send_bundle(b);
        id_bundle   = b2;
        reg_readygo = 1'b1;
        flush       = 1'b1;
        @(negedge clk);
        flush       = 1'b0;
        reg_readygo = 1'b0;
        check_ex("ex_bundle after flush", bubble_value());
        // blocked execute ignores a plain flush
        send_bundle(b);
        ex_allowin = 1'b0;
        flush      = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_ex("ex_bundle flush while blocked", loaded_value(b));
        flush_by_priv = 1'b1;
        @(negedge clk);
        flush_by_priv = 1'b0;
        ex_allowin    = 1'b1;
        check_ex("ex_bundle after priv flush", bubble_value());
    endtask

    task automatic test_back_pressure();
        issue_pkg::bundle_t b;
        issue_pkg::bundle_t b2;
        build_bundle(5'd13, 5'd14, 5'd15, 5'd16, b);
        build_bundle(5'd17, 5'd18, 5'd19, 5'd20, b2);
        send_bundle(b);
        id_bundle     = b2;
        reg_readygo   = 1'b1;
        forward_stall = 1'b1;
        #1;
        check_bit("ex_readygo", 1'b0, ex_readygo);
        check_bit("reg_allowin", 1'b0, reg_allowin);
        repeat (3) begin
            @(negedge clk);
            check_ex("ex_bundle under forward stall", loaded_value(b));
        end
        forward_stall = 1'b0;
        @(negedge clk);
        reg_readygo = 1'b0;
        check_ex("ex_bundle after stall release", loaded_value(b2));
        @(negedge clk);
        check_ex("ex_bundle bubble insertion", bubble_value());
    endtask

    initial begin
        lfsr          = 32'hb88caf6a;
        n_errors      = 0;
        n_checks      = 0;
        aresetn       = 1'b0;
        flush         = 1'b0;
        flush_by_priv = 1'b0;
        reg_readygo   = 1'b0;
        ex_allowin    = 1'b1;
        forward_stall = 1'b0;
        id_bundle     = '0;
        wb0           = '0;
        wb1           = '0;
        fwd           = '0;
        for (int i = 0; i < `RR_NREG; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;

        test_reset();
        test_reg_reads();
        for (int p = 0; p < 4; p++) begin
            test_load_use(4'b0000, 5'd5, p, `RR_LOAD_SHADOW + 1);
        end
        // store with the same rd, then a load to r0
        test_load_use(4'b0100, 5'd5, 0, 0);
        test_load_use(4'b0000, 5'd0, 1, 0);
        test_forward_patch();
        test_flushes();
        test_back_pressure();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== reg_read_stage.f ====
+incdir+.
issue_pkg.sv
bypass_pkg.sv
regfile.sv
load_use_guard.sv
ex_issue_reg.sv
reg_read_stage.sv
tb_reg_read_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the register-read stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_reg_read_stage \
    -f reg_read_stage.f \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi

echo "PASS"
exit 0
